// ==== memPkg.sv ====
package memPkg;

    // Word and lane geometry.
    localparam int WordBits = 32;
    localparam int NumLanes = 4;

    typedef logic [WordBits/NumLanes-1:0] laneByteT;  // One byte per lane.
    typedef logic [WordBits-1:0]          wordT;
    typedef logic [NumLanes-1:0]          strbT;      // Bit i enables lane i.

    // APB response codes on pslverr.
    localparam logic RespOkay   = 1'b0;
    localparam logic RespSlvErr = 1'b1;

    // Data-side request for one lane, before it goes onto the lane bus.
    typedef struct packed {
        logic     en;     // Port active this cycle.
        logic     we;     // Write when set, read otherwise.
        laneByteT wdata;
    } laneReqT;

endpackage

// ==== byteLaneIf.sv ====
interface byteLaneIf #(
    parameter int DepthWords = 1024
);
    import memPkg::*;

    localparam int IdxBits = $clog2(DepthWords);

    // Fetch side, read only.
    logic               fetchEn;
    logic [IdxBits-1:0] fetchIdx;
    laneByteT           fetchRdata;

    // Data side from APB.
    logic               dataEn;
    logic               dataWe;
    logic [IdxBits-1:0] dataIdx;
    laneByteT           dataWdata;
    laneByteT           dataRdata;

    modport decoder (
        output fetchEn, fetchIdx, dataEn, dataWe, dataIdx, dataWdata
    );

    modport bank (
        input  fetchEn, fetchIdx, dataEn, dataWe, dataIdx, dataWdata,
        output fetchRdata, dataRdata
    );

    modport merge (
        input fetchRdata, dataRdata
    );

endinterface

// ==== memPortDecode.sv ====
module memPortDecode #(
    parameter int AddrWidth  = 32,
    parameter int DepthWords = 1024
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 fetchValid,
    input  logic [AddrWidth-1:0] fetchAddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [AddrWidth-1:0] paddr,
    input  memPkg::wordT         pwdata,
    input  memPkg::strbT         pstrb,
    byteLaneIf.decoder           lane [memPkg::NumLanes],
    output logic                 fetchPending,
    output logic                 dataErr
);
    import memPkg::*;

    localparam int IdxBits  = $clog2(DepthWords);
    localparam int ByteBits = $bits(laneByteT);

    // First byte address past the end of memory.
    localparam logic [AddrWidth:0] AddrLimit = (AddrWidth + 1)'(DepthWords * 4);

    logic               addrBad;
    logic               setupRead;
    logic               accessWrite;
    logic [IdxBits-1:0] fetchIdx;
    logic [IdxBits-1:0] dataIdx;
    laneReqT            laneReq [NumLanes];

    // Word index, low byte bits dropped. Wraps at DepthWords.
    assign fetchIdx = fetchAddr[IdxBits+1:2];
    assign dataIdx  = paddr[IdxBits+1:2];

    // Misaligned or beyond the last word.
    assign addrBad = (paddr[1:0] != 2'b00) || ({1'b0, paddr} >= AddrLimit);

    // Reads go to the banks at the setup edge so prdata is ready in access.
    assign setupRead   = psel && !penable && !pwrite && !addrBad;
    assign accessWrite = psel && penable && pwrite && !addrBad;  // Commits at access edge.

    assign dataErr = psel && penable && addrBad;

    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        assign laneReq[i].we    = accessWrite && pstrb[i];
        assign laneReq[i].en    = setupRead || laneReq[i].we;
        assign laneReq[i].wdata = pwdata[ByteBits*i +: ByteBits];

        // Every lane sees the same word index.
        assign lane[i].fetchEn  = fetchValid;
        assign lane[i].fetchIdx = fetchIdx;

        assign lane[i].dataEn    = laneReq[i].en;
        assign lane[i].dataWe    = laneReq[i].we;
        assign lane[i].dataIdx   = dataIdx;
        assign lane[i].dataWdata = laneReq[i].wdata;
    end

    // Fetch data shows up one cycle after the request.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchPending <= 1'b0;
        end else begin
            fetchPending <= fetchValid;
        end
    end

endmodule

// ==== memByteBank.sv ====
module memByteBank #(
    parameter int DepthWords = 1024
) (
    input logic     clk,
    byteLaneIf.bank lane
);
    import memPkg::*;

    // One byte of every word.
    laneByteT mem [DepthWords];

    // Fetch port.
    always_ff @(posedge clk) begin
        if (lane.fetchEn) begin
            lane.fetchRdata <= mem[lane.fetchIdx];  // Sees the byte before any write this edge.
        end
    end

    // Data port, read or write.
    always_ff @(posedge clk) begin
        if (lane.dataEn) begin
            if (lane.dataWe) begin
                mem[lane.dataIdx] <= lane.dataWdata;
            end else begin
                lane.dataRdata <= mem[lane.dataIdx];
            end
        end
    end

endmodule

// ==== memReadMerge.sv ====
module memReadMerge (
    input  logic         clk,
    input  logic         arstN,
    byteLaneIf.merge     lane [memPkg::NumLanes],
    input  logic         fetchPending,
    input  logic         dataErr,
    input  logic         psel,
    input  logic         penable,
    output logic         fetchDataValid,
    output memPkg::wordT fetchData,
    output memPkg::wordT prdata,
    output logic         pready,
    output logic         pslverr
);
    import memPkg::*;

    localparam int ByteBits = $bits(laneByteT);

    wordT dataWord;
    logic access;
    logic setupSeen;

    // Lane 0 holds the lowest byte.
    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        assign fetchData[ByteBits*i +: ByteBits] = lane[i].fetchRdata;
        assign dataWord[ByteBits*i +: ByteBits]  = lane[i].dataRdata;
    end

    assign fetchDataValid = fetchPending;

    // Set when the previous cycle was an APB setup phase.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            setupSeen <= 1'b0;
        end else begin
            setupSeen <= psel && !penable;
        end
    end

    assign access = psel && penable;
    assign pready = access;  // No wait states.

    // Bank data is only meaningful right after a setup edge.
    assign prdata  = (access && setupSeen && !dataErr) ? dataWord : '0;
    assign pslverr = dataErr ? RespSlvErr : RespOkay;

endmodule

// ==== memSubsystem.sv ====
module memSubsystem #(
    parameter int AddrWidth  = 32,
    parameter int DepthWords = 1024
) (
    input  logic                 clk,
    input  logic                 arstN,
    // Instruction fetch.
    input  logic                 fetchValid,
    input  logic [AddrWidth-1:0] fetchAddr,
    output logic                 fetchDataValid,
    output memPkg::wordT         fetchData,
    // APB data port.
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [AddrWidth-1:0] paddr,
    input  memPkg::wordT         pwdata,
    input  memPkg::strbT         pstrb,
    output memPkg::wordT         prdata,
    output logic                 pready,
    output logic                 pslverr
);
    import memPkg::*;

    logic fetchPending;
    logic dataErr;

    byteLaneIf #(.DepthWords(DepthWords)) lane [NumLanes] ();

    memPortDecode #(
        .AddrWidth (AddrWidth),
        .DepthWords(DepthWords)
    ) decode0 (
        .clk         (clk),
        .arstN       (arstN),
        .fetchValid  (fetchValid),
        .fetchAddr   (fetchAddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .lane        (lane),
        .fetchPending(fetchPending),
        .dataErr     (dataErr)
    );

    // One bank per byte lane.
    for (genvar i = 0; i < NumLanes; i++) begin : gBank
        memByteBank #(.DepthWords(DepthWords)) bank0 (
            .clk (clk),
            .lane(lane[i])
        );
    end

    memReadMerge merge0 (
        .clk           (clk),
        .arstN         (arstN),
        .lane          (lane),
        .fetchPending  (fetchPending),
        .dataErr       (dataErr),
        .psel          (psel),
        .penable       (penable),
        .fetchDataValid(fetchDataValid),
        .fetchData     (fetchData),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr)
    );

endmodule

// ==== tbClock.sv ====
module tbClock #(
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Release lands between edges, like every other input.
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #5 arstN = 1'b1;
    end

endmodule

// ==== memSubsystem_props.sv ====
module memSubsystem_props (
    input logic clk,
    input logic arstN,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic fetchValid,
    input logic fetchDataValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // An access phase always comes right after a setup phase.
    accessAfterSetup: assert property (@(posedge clk) disable iff (!arstN)
        (psel && penable) |-> $past(psel && !penable))
        else $error("APB access phase without a preceding setup phase");

    readyInAccess: assert property (@(posedge clk) disable iff (!arstN)
        (psel && penable) |-> pready)
        else $error("pready low during an APB access phase");

    // Fetch data is valid exactly one cycle after each request.
    fetchOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        fetchValid |=> fetchDataValid)
        else $error("fetchDataValid missing one cycle after fetchValid");

    fetchNoExtra: assert property (@(posedge clk) disable iff (!arstN)
        !fetchValid |=> !fetchDataValid)
        else $error("fetchDataValid raised without a fetch request");

endmodule

bind memSubsystem memSubsystem_props props0 (
    .clk           (clk),
    .arstN         (arstN),
    .psel          (psel),
    .penable       (penable),
    .pready        (pready),
    .fetchValid    (fetchValid),
    .fetchDataValid(fetchDataValid)
);

// ==== memSubsystemTb.sv ====
module memSubsystemTb;
    timeunit 1ns;
    timeprecision 1ps;
    import memPkg::*;

    localparam int AddrWidth         = 32;
    localparam int DepthWords        = 1024;
    localparam int RandomOps         = 200;
    localparam int DirectedTransfers = 40;  // Upper bound over the directed tests.
    localparam int CycleLimit = (DepthWords + DirectedTransfers + RandomOps) * 3 + 100;
    localparam int ByteBits          = $bits(laneByteT);

    logic                 clk;
    logic                 arstN;
    logic                 fetchValid;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDataValid;
    wordT                 fetchData;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AddrWidth-1:0] paddr;
    wordT                 pwdata;
    strbT                 pstrb;
    wordT                 prdata;
    logic                 pready;
    logic                 pslverr;

    wordT                 model [int unsigned];  // Reference memory, word indexed.
    logic [AddrWidth-1:0] fetchReqQ [$];         // Fetches waiting for a free slot.
    wordT                 fetchExpQ [$];
    wordT                 apbExpData [$];
    logic                 apbExpErr [$];
    bit                   apbExpRead [$];
    logic                 fetchWasValid = 1'b0;
    int                   seed = 24;
    int                   cycleCount = 0;

    tbClock clkGen0 (.clk(clk), .arstN(arstN));

    memSubsystem #(
        .AddrWidth (AddrWidth),
        .DepthWords(DepthWords)
    ) dut0 (
        .clk(clk), .arstN(arstN),
        .fetchValid(fetchValid), .fetchAddr(fetchAddr),
        .fetchDataValid(fetchDataValid), .fetchData(fetchData),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    function automatic wordT fillWord(input int unsigned idx);
        return (idx * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;  // Mixes every index bit.
    endfunction

    function automatic logic addrInError(input logic [AddrWidth-1:0] addr);
        return (addr[1:0] != 2'b00) || (addr >= DepthWords * 4);
    endfunction

    // Fetch ignores the low bits and wraps. APB errors read as zero.
    function automatic wordT refRead(input logic [AddrWidth-1:0] addr, input bit isFetch);
        int unsigned idx;
        idx = (addr >> 2) % DepthWords;
        if (!isFetch && addrInError(addr)) begin
            return '0;
        end
        return model.exists(idx) ? model[idx] : '0;
    endfunction

    task automatic refWrite(input logic [AddrWidth-1:0] addr, input wordT data, input strbT strb);
        int unsigned idx;
        wordT        word;
        idx  = addr >> 2;
        word = model.exists(idx) ? model[idx] : '0;
        for (int i = 0; i < NumLanes; i++) begin
            if (strb[i]) begin
                word[ByteBits*i +: ByteBits] = data[ByteBits*i +: ByteBits];
            end
        end
        model[idx] = word;
    endtask

    task automatic abortRun();
        $display("** FAIL **");
        $fatal(1, "Run stopped at %0t.", $time);
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic waitSlot();
        @(posedge clk);
        #5;
    endtask

    // Issues the next queued fetch in this slot, or idles the port.
    task automatic driveFetch();
        if (fetchReqQ.size() > 0) begin
            fetchAddr  = fetchReqQ.pop_front();
            fetchValid = 1'b1;
            fetchExpQ.push_back(refRead(fetchAddr, 1'b1));
        end else begin
            fetchValid = 1'b0;
        end
    endtask

    task automatic idleSlot();
        driveFetch();
        waitSlot();
    endtask

    task automatic apbWrite(input logic [AddrWidth-1:0] addr, input wordT data, input strbT strb);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        driveFetch();
        waitSlot();
        penable = 1'b1;
        apbExpData.push_back('0);
        apbExpErr.push_back(addrInError(addr));
        apbExpRead.push_back(1'b0);
        driveFetch();  // Sampled at the commit edge, so it sees the old word.
        waitSlot();
        if (!addrInError(addr)) begin
            refWrite(addr, data, strb);
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbRead(input logic [AddrWidth-1:0] addr);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        pstrb   = '0;
        driveFetch();
        waitSlot();
        penable = 1'b1;
        apbExpData.push_back(refRead(addr, 1'b0));
        apbExpErr.push_back(addrInError(addr));
        apbExpRead.push_back(1'b1);
        driveFetch();
        waitSlot();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Flops only sample the fetch request here; outputs are checked mid-cycle.
    always @(posedge clk) begin
        fetchWasValid <= fetchValid;
    end

    initial begin : compare
        wordT expWord;
        forever begin
            @(negedge clk);
            checkBit("fetchDataValid", fetchWasValid, fetchDataValid);
            if (fetchWasValid) begin
                if (fetchExpQ.size() == 0) begin
                    $display("Fetch data showed up with no fetch outstanding at %0t.", $time);
                    abortRun();
                end
                checkWord("fetchData", fetchExpQ.pop_front(), fetchData);
            end
            checkBit("pready", psel && penable, pready);
            if (psel && penable) begin
                if (apbExpErr.size() == 0) begin
                    $display("APB access phase with no expected response at %0t.", $time);
                    abortRun();
                end
                checkBit("pslverr", apbExpErr.pop_front(), pslverr);
                expWord = apbExpData.pop_front();
                if (apbExpRead.pop_front()) begin
                    checkWord("prdata", expWord, prdata);
                end
            end else begin
                checkBit("pslverr", 1'b0, pslverr);  // Only raised in access.
            end
        end
    end

    initial begin : timeout
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles.", CycleLimit);
        abortRun();
    end

    initial begin : stimulus
        logic [AddrWidth-1:0] addr;
        wordT                 data;
        strbT                 strb;
        int                   op;
        strbT                 strbSet [6] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'hA};

        fetchValid = 1'b0;
        fetchAddr  = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pstrb      = '0;
        wait (arstN === 1'b1);
        waitSlot();

        // Memory has no reset, so every word is written first.
        for (int i = 0; i < DepthWords; i++) begin
            apbWrite(i * 4, fillWord(i), 4'hF);
        end

        apbWrite(32'h100, 32'hDEAD_BEEF, 4'hF);
        apbRead(32'h100);

        // Partial writes.
        foreach (strbSet[i]) begin
            apbWrite(32'h204, $random(seed), strbSet[i]);
            apbRead(32'h204);
        end

        // Back-to-back fetches. The last two wrap past the depth.
        fetchReqQ = '{32'h100, 32'h204, 32'h0, 32'hFFC, 32'h1100, 32'hFFFF_F204};
        while (fetchReqQ.size() > 0) begin
            idleSlot();
        end
        idleSlot();

        // Misaligned and out-of-range accesses followed by reads of the words behind them.
        apbWrite(32'h302, 32'h1111_1111, 4'hF);
        apbRead(32'h302);
        apbWrite(32'h1000, 32'h2222_2222, 4'hF);
        apbRead(32'h2000);
        apbRead(32'h300);
        apbRead(32'h0);

        // Second fetch lands on the commit edge and the third comes after it.
        fetchReqQ = '{32'h400, 32'h400, 32'h400};
        apbWrite(32'h400, 32'hCAFE_F00D, 4'hF);
        idleSlot();
        idleSlot();

        for (int n = 0; n < RandomOps; n++) begin
            op   = $unsigned($random(seed)) % 3;
            addr = $random(seed);
            if (addr[7:4] != 4'h0) begin
                addr = (addr % DepthWords) << 2;  // Mostly legal addresses.
            end
            data = $random(seed);
            strb = $random(seed);
            case (op)
                0: apbWrite(addr, data, strb);
                1: apbRead(addr);
                default: begin
                    repeat (1 + $unsigned($random(seed)) % 3) begin
                        fetchReqQ.push_back($random(seed));
                    end
                    idleSlot();
                end
            endcase
        end

        while (fetchReqQ.size() > 0) begin
            idleSlot();
        end
        repeat (2) begin
            idleSlot();
        end

        if (fetchExpQ.size() != 0 || apbExpErr.size() != 0) begin
            $display("Responses still outstanding at the end of the run.");
            abortRun();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
memPkg.sv
byteLaneIf.sv
memPortDecode.sv
memByteBank.sv
memReadMerge.sv
memSubsystem.sv
tbClock.sv
memSubsystem_props.sv
memSubsystemTb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - memPkg.sv
  - byteLaneIf.sv
  - memPortDecode.sv
  - memByteBank.sv
  - memReadMerge.sv
  - memSubsystem.sv
  - target: test
    files:
      - tbClock.sv
      - memSubsystem_props.sv
      - memSubsystemTb.sv
